/* verilog/acpi_geom_pkg.sv */
/* Image geometry for the green interpolator: frame size, border,
   line count, pixel, address and counter types */

package acpi_geom_pkg;

	localparam int IMG_W  = 128;
	localparam int IMG_H  = 128;
	localparam int PIX_W  = 8;
	localparam int ADDR_W = 14;

	// Sites closer than this to any edge give no result
	localparam int BORDER = 2;

	// Earlier rows held by the line buffer
	localparam int LINES  = 4;

	typedef logic [PIX_W-1:0] pixel_t;

	// Row times IMG_W plus column
	typedef logic [ADDR_W-1:0] addr_t;

	typedef logic [6:0] col_t;
	typedef logic [6:0] row_t;

endpackage

/* verilog/acpi_calc_pkg.sv */
/* Arithmetic widths and types for the gradient and estimate
   pipeline, and the direction code between its stages */

package acpi_calc_pkg;

	// Signed intermediates, wide enough for four times a pixel sum
	localparam int SUM_W = 13;

	typedef logic signed [SUM_W-1:0] sum_t;

	// Every estimate term is divided by eight at the end
	localparam int EST_SHIFT = 3;

	// Gradient decision
	typedef enum logic [1:0] {
		HORIZ,
		VERT,
		EVEN
	} dir_t;

endpackage

/* verilog/acpi_line_buffer.sv */
/* Cascade of one-row delay memories, gives the current column
   of the four previous rows */

`timescale 1ns/1ps

module acpi_line_buffer (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  pix_valid,
	input  acpi_geom_pkg::col_t   col,
	input  acpi_geom_pkg::pixel_t pix_in,
	output acpi_geom_pkg::pixel_t taps [acpi_geom_pkg::LINES]
);

	// mem[0] holds the previous row, mem[LINES-1] the oldest
	acpi_geom_pkg::pixel_t mem [acpi_geom_pkg::LINES][acpi_geom_pkg::IMG_W];

	// Read taps nearest row first
	always_comb begin
		for (int k = 0; k < acpi_geom_pkg::LINES; k++) begin
			taps[k] = mem[k][col];
		end
	end

	// Each row moves one memory down the cascade at the same column
	always_ff @(posedge clk) begin
		if (pix_valid) begin
			mem[0][col] <= pix_in;
			for (int k = 1; k < acpi_geom_pkg::LINES; k++) begin
				mem[k][col] <= mem[k-1][col];
			end
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Checks
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// A written pixel and its column must be known
	write_known: assert property (
		@(posedge clk) disable iff (rst)
		pix_valid |-> !$isunknown({col, pix_in})
	);

endmodule

/* verilog/acpi_window.sv */
/* Raster counters, 5x5 cross window registers and the decision
   which centers are interior red/blue sites */

`timescale 1ns/1ps

module acpi_window (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  pix_valid,
	input  acpi_geom_pkg::pixel_t pix_data,
	output logic                  win_valid,
	output logic                  win_last,
	output acpi_geom_pkg::addr_t  win_addr,
	output acpi_geom_pkg::pixel_t c_pix,
	output acpi_geom_pkg::pixel_t l1_pix,
	output acpi_geom_pkg::pixel_t r1_pix,
	output acpi_geom_pkg::pixel_t l2_pix,
	output acpi_geom_pkg::pixel_t r2_pix,
	output acpi_geom_pkg::pixel_t u1_pix,
	output acpi_geom_pkg::pixel_t d1_pix,
	output acpi_geom_pkg::pixel_t u2_pix,
	output acpi_geom_pkg::pixel_t d2_pix
);

	acpi_geom_pkg::row_t   row;
	acpi_geom_pkg::col_t   col;
	acpi_geom_pkg::row_t   cen_row;
	acpi_geom_pkg::col_t   cen_col;
	logic                  interior;
	logic                  site;
	logic                  last_site;
	acpi_geom_pkg::pixel_t taps [acpi_geom_pkg::LINES];
	acpi_geom_pkg::pixel_t hsr [5];
	acpi_geom_pkg::pixel_t vsrc [4];
	acpi_geom_pkg::pixel_t vdly [4][2];

	acpi_line_buffer line_buffer_i (
		.clk       (clk),
		.rst       (rst),
		.pix_valid (pix_valid),
		.col       (col),
		.pix_in    (pix_data),
		.taps      (taps)
	);

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Raster position
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			row <= '0;
			col <= '0;
		end else if (pix_valid) begin
			if (int'(col) == acpi_geom_pkg::IMG_W - 1) begin
				col <= '0;
				if (int'(row) == acpi_geom_pkg::IMG_H - 1)
					row <= '0;
				else
					row <= row + 1'b1;
			end else begin
				col <= col + 1'b1;
			end
		end
	end

	// The incoming pixel completes the window centered two rows up, two columns left
	assign cen_row  = row - acpi_geom_pkg::row_t'(acpi_geom_pkg::BORDER);
	assign cen_col  = col - acpi_geom_pkg::col_t'(acpi_geom_pkg::BORDER);
	assign interior = (int'(row) >= 2 * acpi_geom_pkg::BORDER) &&
		(int'(col) >= 2 * acpi_geom_pkg::BORDER);
	// Red and blue sites have an odd row plus column
	assign site     = cen_row[0] ^ cen_col[0];
	// Bottom interior row is odd, so its last site sits one column in
	assign last_site = (int'(cen_row) == acpi_geom_pkg::IMG_H - 1 - acpi_geom_pkg::BORDER) &&
		(int'(cen_col) == acpi_geom_pkg::IMG_W - 2 - acpi_geom_pkg::BORDER);

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			win_valid <= 1'b0;
			win_last  <= 1'b0;
		end else begin
			win_valid <= pix_valid && interior && site;
			win_last  <= pix_valid && interior && site && last_site;
		end
	end

	always_ff @(posedge clk) begin
		if (pix_valid)
			win_addr <= acpi_geom_pkg::addr_t'({cen_row, cen_col});
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Cross window
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// Vertical sources U2, U1, D1 and D2 in this order
	always_comb begin
		vsrc[0] = taps[3];
		vsrc[1] = taps[2];
		vsrc[2] = taps[0];
		vsrc[3] = pix_data;
	end

	always_ff @(posedge clk) begin
		if (pix_valid) begin
			// Center row runs through the horizontal shift register
			hsr[0] <= taps[1];
			for (int i = 1; i < 5; i++) begin
				hsr[i] <= hsr[i-1];
			end
			for (int k = 0; k < 4; k++) begin
				vdly[k][0] <= vsrc[k];
				vdly[k][1] <= vdly[k][0];
			end
			u2_pix <= vdly[0][1];
			u1_pix <= vdly[1][1];
			d1_pix <= vdly[2][1];
			d2_pix <= vdly[3][1];
		end
	end

	assign r2_pix = hsr[0];
	assign r1_pix = hsr[1];
	assign c_pix  = hsr[2];
	assign l1_pix = hsr[3];
	assign l2_pix = hsr[4];

	// Every cross pixel of a reported window comes from a written row
	window_known: assert property (
		@(posedge clk) disable iff (rst)
		win_valid |-> !$isunknown({c_pix, l1_pix, r1_pix, l2_pix, r2_pix,
			u1_pix, d1_pix, u2_pix, d2_pix})
	);

endmodule

/* verilog/acpi_green.sv */
/* Two-stage pipeline: gradients and direction, then the chosen
   average estimate plus correction as the green value */

`timescale 1ns/1ps

module acpi_green (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  win_valid,
	input  logic                  win_last,
	input  acpi_geom_pkg::addr_t  win_addr,
	input  acpi_geom_pkg::pixel_t c_pix,
	input  acpi_geom_pkg::pixel_t l1_pix,
	input  acpi_geom_pkg::pixel_t r1_pix,
	input  acpi_geom_pkg::pixel_t l2_pix,
	input  acpi_geom_pkg::pixel_t r2_pix,
	input  acpi_geom_pkg::pixel_t u1_pix,
	input  acpi_geom_pkg::pixel_t d1_pix,
	input  acpi_geom_pkg::pixel_t u2_pix,
	input  acpi_geom_pkg::pixel_t d2_pix,
	output logic                  res_valid,
	output logic                  res_last,
	output acpi_geom_pkg::addr_t  res_addr,
	output acpi_geom_pkg::pixel_t res_data
);

	function automatic acpi_calc_pkg::sum_t abs_diff(
		acpi_calc_pkg::sum_t a,
		acpi_calc_pkg::sum_t b
	);
		return (a >= b) ? a - b : b - a;
	endfunction

	acpi_calc_pkg::sum_t  c2, h_near, v_near, h_far, v_far, dh, dv;
	acpi_calc_pkg::dir_t  dir;

	logic                 s1_valid, s1_last;
	acpi_geom_pkg::addr_t s1_addr;
	acpi_calc_pkg::dir_t  s1_dir;
	acpi_calc_pkg::sum_t  s1_c4, s1_h_near, s1_v_near, s1_h_far, s1_v_far;
	acpi_calc_pkg::sum_t  avg, corr;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Stage 1 gradients
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always_comb begin
		c2     = acpi_calc_pkg::sum_t'(c_pix) <<< 1;
		h_near = acpi_calc_pkg::sum_t'(l1_pix) + acpi_calc_pkg::sum_t'(r1_pix);
		v_near = acpi_calc_pkg::sum_t'(u1_pix) + acpi_calc_pkg::sum_t'(d1_pix);
		h_far  = acpi_calc_pkg::sum_t'(l2_pix) + acpi_calc_pkg::sum_t'(r2_pix);
		v_far  = acpi_calc_pkg::sum_t'(u2_pix) + acpi_calc_pkg::sum_t'(d2_pix);
		dh = abs_diff(acpi_calc_pkg::sum_t'(l1_pix), acpi_calc_pkg::sum_t'(r1_pix)) +
			abs_diff(c2, h_far);
		dv = abs_diff(acpi_calc_pkg::sum_t'(u1_pix), acpi_calc_pkg::sum_t'(d1_pix)) +
			abs_diff(c2, v_far);
		if (dh < dv)
			dir = acpi_calc_pkg::HORIZ;
		else if (dv < dh)
			dir = acpi_calc_pkg::VERT;
		else
			dir = acpi_calc_pkg::EVEN;
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			s1_valid  <= 1'b0;
			s1_last   <= 1'b0;
			res_valid <= 1'b0;
			res_last  <= 1'b0;
		end else begin
			s1_valid  <= win_valid;
			s1_last   <= win_last;
			res_valid <= s1_valid;
			res_last  <= s1_last;
		end
	end

	always_ff @(posedge clk) begin
		s1_addr   <= win_addr;
		s1_dir    <= dir;
		s1_c4     <= c2 <<< 1;
		s1_h_near <= h_near;
		s1_v_near <= v_near;
		s1_h_far  <= h_far;
		s1_v_far  <= v_far;
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Stage 2 estimate and correction
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always_comb begin
		case (s1_dir)
			acpi_calc_pkg::HORIZ: begin
				avg  = (s1_h_near <<< 2) >>> acpi_calc_pkg::EST_SHIFT;
				corr = abs_diff(s1_c4, s1_h_far <<< 1) >>> acpi_calc_pkg::EST_SHIFT;
			end
			acpi_calc_pkg::VERT: begin
				avg  = (s1_v_near <<< 2) >>> acpi_calc_pkg::EST_SHIFT;
				corr = abs_diff(s1_c4, s1_v_far <<< 1) >>> acpi_calc_pkg::EST_SHIFT;
			end
			default: begin
				avg  = ((s1_h_near + s1_v_near) <<< 1) >>> acpi_calc_pkg::EST_SHIFT;
				corr = abs_diff(s1_c4, s1_h_far + s1_v_far) >>> acpi_calc_pkg::EST_SHIFT;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		res_addr <= s1_addr;
		// Sum wraps to the pixel width
		res_data <= acpi_geom_pkg::pixel_t'(avg + corr);
	end

	// A reported result carries a known address and green value
	res_known: assert property (
		@(posedge clk) disable iff (rst)
		res_valid |-> !$isunknown({res_addr, res_data})
	);

endmodule

/* verilog/acpi_top.sv */
/* Top level of the green interpolator: window builder feeding
   the gradient and estimate pipeline */

`timescale 1ns/1ps

module acpi_top (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  pix_valid,
	input  acpi_geom_pkg::pixel_t pix_data,
	output logic                  acpi_valid,
	output acpi_geom_pkg::addr_t  acpi_addr,
	output acpi_geom_pkg::pixel_t acpi_data,
	output logic                  finish
);

	logic                  win_valid;
	logic                  win_last;
	acpi_geom_pkg::addr_t  win_addr;
	acpi_geom_pkg::pixel_t c_pix, l1_pix, r1_pix, l2_pix, r2_pix;
	acpi_geom_pkg::pixel_t u1_pix, d1_pix, u2_pix, d2_pix;

	acpi_window window_i (
		.clk       (clk),
		.rst       (rst),
		.pix_valid (pix_valid),
		.pix_data  (pix_data),
		.win_valid (win_valid),
		.win_last  (win_last),
		.win_addr  (win_addr),
		.c_pix     (c_pix),
		.l1_pix    (l1_pix),
		.r1_pix    (r1_pix),
		.l2_pix    (l2_pix),
		.r2_pix    (r2_pix),
		.u1_pix    (u1_pix),
		.d1_pix    (d1_pix),
		.u2_pix    (u2_pix),
		.d2_pix    (d2_pix)
	);

	// Finish is the last flag of the final result
	acpi_green green_i (
		.clk       (clk),
		.rst       (rst),
		.win_valid (win_valid),
		.win_last  (win_last),
		.win_addr  (win_addr),
		.c_pix     (c_pix),
		.l1_pix    (l1_pix),
		.r1_pix    (r1_pix),
		.l2_pix    (l2_pix),
		.r2_pix    (r2_pix),
		.u1_pix    (u1_pix),
		.d1_pix    (d1_pix),
		.u2_pix    (u2_pix),
		.d2_pix    (d2_pix),
		.res_valid (acpi_valid),
		.res_last  (finish),
		.res_addr  (acpi_addr),
		.res_data  (acpi_data)
	);

endmodule

/* verification/acpi_tb_ref.svh */
/* Image type, green reference model and typed compare tasks
   for the interpolator testbench */

`ifndef ACPI_TB_REF_SVH
`define ACPI_TB_REF_SVH

typedef acpi_geom_pkg::pixel_t image_t [acpi_geom_pkg::IMG_H][acpi_geom_pkg::IMG_W];

function automatic acpi_calc_pkg::sum_t magnitude(input acpi_calc_pkg::sum_t x);
	return (x < 0) ? -x : x;
endfunction

// Adaptive green estimate at one red or blue site
function automatic acpi_geom_pkg::pixel_t green_ref(input image_t img, input int row,
	input int col);
	acpi_calc_pkg::sum_t c, l1, r1, l2, r2, u1, d1, u2, d2;
	acpi_calc_pkg::sum_t dh, dv, avg, corr;
	acpi_calc_pkg::dir_t dir;
	c  = acpi_calc_pkg::sum_t'(img[row][col]);
	l1 = acpi_calc_pkg::sum_t'(img[row][col-1]);
	r1 = acpi_calc_pkg::sum_t'(img[row][col+1]);
	l2 = acpi_calc_pkg::sum_t'(img[row][col-2]);
	r2 = acpi_calc_pkg::sum_t'(img[row][col+2]);
	u1 = acpi_calc_pkg::sum_t'(img[row-1][col]);
	d1 = acpi_calc_pkg::sum_t'(img[row+1][col]);
	u2 = acpi_calc_pkg::sum_t'(img[row-2][col]);
	d2 = acpi_calc_pkg::sum_t'(img[row+2][col]);
	dh = magnitude(l1 - r1) + magnitude(2 * c - (l2 + r2));
	dv = magnitude(u1 - d1) + magnitude(2 * c - (u2 + d2));
	if (dh < dv)
		dir = acpi_calc_pkg::HORIZ;
	else if (dv < dh)
		dir = acpi_calc_pkg::VERT;
	else
		dir = acpi_calc_pkg::EVEN;
	case (dir)
		acpi_calc_pkg::HORIZ: begin
			avg  = (4 * (l1 + r1)) >>> acpi_calc_pkg::EST_SHIFT;
			corr = magnitude(4 * c - 2 * (l2 + r2)) >>> acpi_calc_pkg::EST_SHIFT;
		end
		acpi_calc_pkg::VERT: begin
			avg  = (4 * (u1 + d1)) >>> acpi_calc_pkg::EST_SHIFT;
			corr = magnitude(4 * c - 2 * (u2 + d2)) >>> acpi_calc_pkg::EST_SHIFT;
		end
		default: begin
			avg  = (2 * (l1 + r1 + u1 + d1)) >>> acpi_calc_pkg::EST_SHIFT;
			corr = magnitude(4 * c - (l2 + r2 + u2 + d2)) >>> acpi_calc_pkg::EST_SHIFT;
		end
	endcase
	return acpi_geom_pkg::pixel_t'(avg + corr);
endfunction

task automatic compare_pixel(input string name, input acpi_geom_pkg::pixel_t exp,
	input acpi_geom_pkg::pixel_t act);
	if (act !== exp)
		abort_run($sformatf("mismatch %s: expected %02h, actual %02h", name, exp, act));
endtask

task automatic compare_addr(input string name, input acpi_geom_pkg::addr_t exp,
	input acpi_geom_pkg::addr_t act);
	if (act !== exp)
		abort_run($sformatf("mismatch %s: expected %04h, actual %04h", name, exp, act));
endtask

task automatic compare_flag(input string name, input logic exp, input logic act);
	if (act !== exp)
		abort_run($sformatf("mismatch %s: expected %b, actual %b", name, exp, act));
endtask

`endif

/* verification/acpi_tb.sv */
/* Testbench for the green interpolator: clock, reset, raster stimulus,
   expected-result queue, checker and watchdog */

`timescale 1ns/1ps

module acpi_tb;

	localparam int CLK_HALF     = 10;
	localparam int DRIVE_DELAY  = 2;
	localparam int RESET_CYCLES = 3;
	localparam int FRAMES       = 2;
	localparam int LATENCY      = 3;
	localparam int RESULTS_PER_FRAME =
		(acpi_geom_pkg::IMG_H - 2 * acpi_geom_pkg::BORDER) *
		(acpi_geom_pkg::IMG_W - 2 * acpi_geom_pkg::BORDER) / 2;
	// Two frames plus half again for idle gaps and some slack
	localparam int WATCH_CYCLES =
		(FRAMES * acpi_geom_pkg::IMG_W * acpi_geom_pkg::IMG_H * 3) / 2 + 100;

	typedef struct packed {
		acpi_geom_pkg::addr_t  addr;
		acpi_geom_pkg::pixel_t data;
		logic                  last;
		logic [31:0]           cycle;
	} expect_t;

	logic                  clk;
	logic                  rst;
	logic                  pix_valid;
	acpi_geom_pkg::pixel_t pix_data;
	logic                  acpi_valid;
	acpi_geom_pkg::addr_t  acpi_addr;
	acpi_geom_pkg::pixel_t acpi_data;
	logic                  finish;

	task automatic abort_run(input string what);
		$display("%s", what);
		$display(">>> FAIL");
		$fatal(1, "run stopped at first error");
	endtask

`include "acpi_tb_ref.svh"

	image_t      img;
	expect_t     exp_q [$];
	expect_t     front;
	logic        due;
	int unsigned cycle = 0;
	int          result_count = 0;
	int          frame_results = 0;
	int          frames_done = 0;

	acpi_top dut_i (
		.clk        (clk),
		.rst        (rst),
		.pix_valid  (pix_valid),
		.pix_data   (pix_data),
		.acpi_valid (acpi_valid),
		.acpi_addr  (acpi_addr),
		.acpi_data  (acpi_data),
		.finish     (finish)
	);

	initial begin
		clk = 1'b0;
		forever #CLK_HALF clk = ~clk;
	end

	always @(posedge clk) cycle <= cycle + 1;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Stimulus
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// Random image with flat, row-ramp and column-ramp bands
	task automatic fill_image();
		for (int r = 0; r < acpi_geom_pkg::IMG_H; r++) begin
			for (int c = 0; c < acpi_geom_pkg::IMG_W; c++) begin
				if (r >= 10 && r < 20)
					img[r][c] = 8'h5a;
				else if (r >= 30 && r < 40)
					img[r][c] = acpi_geom_pkg::pixel_t'(r * 6 + 3);
				else if (r >= 50 && r < 60)
					img[r][c] = acpi_geom_pkg::pixel_t'(c * 2 + 1);
				else
					img[r][c] = acpi_geom_pkg::pixel_t'($urandom);
			end
		end
	endtask

	task automatic push_expected(input int cr, input int cc);
		expect_t e;
		e.addr  = acpi_geom_pkg::addr_t'(cr * acpi_geom_pkg::IMG_W + cc);
		e.data  = green_ref(img, cr, cc);
		// No further odd site fits in the bottom interior row
		e.last  = (cr == acpi_geom_pkg::IMG_H - 1 - acpi_geom_pkg::BORDER) &&
			(cc + 2 > acpi_geom_pkg::IMG_W - 1 - acpi_geom_pkg::BORDER);
		e.cycle = cycle + LATENCY;
		exp_q.push_back(e);
	endtask

	task automatic stream_frame();
		int cr;
		int cc;
		for (int r = 0; r < acpi_geom_pkg::IMG_H; r++) begin
			for (int c = 0; c < acpi_geom_pkg::IMG_W; c++) begin
				if (($urandom % 4) == 0) begin
					@(posedge clk);
					#DRIVE_DELAY;
					pix_valid = 1'b0;
					pix_data  = acpi_geom_pkg::pixel_t'($urandom);
				end
				@(posedge clk);
				#DRIVE_DELAY;
				pix_valid = 1'b1;
				pix_data  = img[r][c];
				cr = r - acpi_geom_pkg::BORDER;
				cc = c - acpi_geom_pkg::BORDER;
				if (cr >= acpi_geom_pkg::BORDER && cc >= acpi_geom_pkg::BORDER &&
					((cr + cc) % 2) == 1)
					push_expected(cr, cc);
			end
		end
	endtask

	initial begin
		void'($urandom(32'h08a4f473));
		rst       = 1'b1;
		pix_valid = 1'b0;
		pix_data  = '0;
		repeat (RESET_CYCLES) @(posedge clk);
		#DRIVE_DELAY;
		rst = 1'b0;
		for (int f = 0; f < FRAMES; f++) begin
			fill_image();
			stream_frame();
		end
		@(posedge clk);
		#DRIVE_DELAY;
		pix_valid = 1'b0;
		while (exp_q.size() != 0) @(posedge clk);
		repeat (2 * LATENCY) @(posedge clk);
		if (frames_done != FRAMES || result_count != FRAMES * RESULTS_PER_FRAME)
			abort_run($sformatf("only %0d frames with %0d results were completed",
				frames_done, result_count));
		else begin
			$display(">>> PASS");
			$finish;
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Checker and watchdog
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// Outputs are sampled mid-cycle and each result is due exactly in its expected cycle
	always @(negedge clk) begin
		if (!rst) begin
			due = (exp_q.size() != 0) && (exp_q[0].cycle == cycle);
			compare_flag($sformatf("acpi_valid at cycle %0d", cycle), due, acpi_valid);
			if (due) begin
				front = exp_q.pop_front();
				compare_addr($sformatf("acpi_addr of result %0d", result_count),
					front.addr, acpi_addr);
				compare_pixel($sformatf("acpi_data at address %04h", front.addr),
					front.data, acpi_data);
				compare_flag($sformatf("finish at address %04h", front.addr),
					front.last, finish);
				result_count++;
				frame_results++;
				if (front.last) begin
					if (frame_results != RESULTS_PER_FRAME)
						abort_run($sformatf("frame %0d gave %0d results instead of %0d",
							frames_done, frame_results, RESULTS_PER_FRAME));
					frame_results = 0;
					frames_done++;
				end
			end else begin
				compare_flag($sformatf("finish at cycle %0d", cycle), 1'b0, finish);
			end
		end
	end

	initial begin
		repeat (WATCH_CYCLES + RESET_CYCLES) @(posedge clk);
		abort_run($sformatf("watchdog expired after %0d cycles with %0d results pending",
			WATCH_CYCLES + RESET_CYCLES, exp_q.size()));
	end

endmodule

/* list.f */
+incdir+verification
verilog/acpi_geom_pkg.sv
verilog/acpi_calc_pkg.sv
verilog/acpi_line_buffer.sv
verilog/acpi_window.sv
verilog/acpi_green.sv
verilog/acpi_top.sv
verification/acpi_tb.sv
